// File: rtl/rv64_isa_pkg.sv
`default_nettype none

package rv64_isa_pkg;

  typedef enum logic [6:0] {
    op_imm    = 7'b0010011,
    op_imm_32 = 7'b0011011,
    op        = 7'b0110011,
    op_32     = 7'b0111011,
    lui       = 7'b0110111,
    auipc     = 7'b0010111,
    load      = 7'b0000011,
    store     = 7'b0100011,
    jal       = 7'b1101111,
    jalr      = 7'b1100111,
    branch    = 7'b1100011,
    system    = 7'b1110011
  } opcode_e;

  // alu funct3
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // branch conditions
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // multiply variants, funct3[2] set means divide
  localparam logic [2:0] F3_MUL    = 3'b000;
  localparam logic [2:0] F3_MULH   = 3'b001;
  localparam logic [2:0] F3_MULHSU = 3'b010;
  localparam logic [2:0] F3_MULHU  = 3'b011;

  localparam logic [6:0] F7_MULDIV = 7'b0000001;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } r_fields_t;

  typedef struct packed {
    logic [11:0] imm12;  // shamt in [5:0], arith bit at [10]
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } i_fields_t;

  typedef union packed {
    r_fields_t r_view;
    i_fields_t i_view;
  } instr_u;

endpackage

`default_nettype wire

// File: rtl/exu_pkg.sv
`default_nettype none

package exu_pkg;

  localparam int XLEN = 64;

  typedef logic [XLEN-1:0] xlen_t;

  // default step count of the shift-add multiplier
  localparam int MUL_CYCLES = 64;

  typedef enum logic [4:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_or,
    alu_and,
    alu_addw,
    alu_subw,
    alu_sllw,
    alu_srlw,
    alu_sraw,
    alu_pass_b,    // lui
    alu_branch,    // 0/1 decision
    alu_jalr_tgt,
    alu_zero
  } alu_op_e;

  typedef struct packed {
    logic a_signed;
    logic b_signed;
    logic take_high;  // upper half of the 128-bit product
    logic word;       // low 32 bits, sign extended
  } mul_req_t;

endpackage

`default_nettype wire

// File: rtl/alu_op_decode.sv
`default_nettype none

module alu_op_decode (
  input  wire rv64_isa_pkg::instr_u instr_i,
  output exu_pkg::alu_op_e          op_o,
  output logic                      is_mul_o,
  output exu_pkg::mul_req_t         mul_req_o
);

  rv64_isa_pkg::opcode_e opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic                  imm_arith;

  assign opcode    = instr_i.r_view.opcode;
  assign funct3    = instr_i.r_view.funct3;
  assign funct7    = instr_i.r_view.funct7;    // R-type and *IW shifts
  assign imm_arith = instr_i.i_view.imm12[10]; // 64-bit shifts, shamt[5] sits below

  always_comb begin
    op_o      = exu_pkg::alu_zero;
    is_mul_o  = 1'b0;
    mul_req_o = '0;
    case (opcode)
      rv64_isa_pkg::op, rv64_isa_pkg::op_imm: begin
        if (opcode == rv64_isa_pkg::op && funct7 == rv64_isa_pkg::F7_MULDIV) begin
          if (!funct3[2]) begin  // div/rem stay zero
            is_mul_o            = 1'b1;
            mul_req_o.a_signed  = (funct3 == rv64_isa_pkg::F3_MULH) ||
                                  (funct3 == rv64_isa_pkg::F3_MULHSU);
            mul_req_o.b_signed  = (funct3 == rv64_isa_pkg::F3_MULH);
            mul_req_o.take_high = (funct3 != rv64_isa_pkg::F3_MUL);
          end
        end else begin
          case (funct3)
            rv64_isa_pkg::F3_ADD_SUB: op_o = (opcode == rv64_isa_pkg::op && funct7[5]) ?
                                             exu_pkg::alu_sub : exu_pkg::alu_add;
            rv64_isa_pkg::F3_SLL:     op_o = exu_pkg::alu_sll;
            rv64_isa_pkg::F3_SLT:     op_o = exu_pkg::alu_slt;
            rv64_isa_pkg::F3_SLTU:    op_o = exu_pkg::alu_sltu;
            rv64_isa_pkg::F3_XOR:     op_o = exu_pkg::alu_xor;
            rv64_isa_pkg::F3_SRL_SRA: begin
              if (imm_arith) begin  // bit 30 in both formats
                op_o = exu_pkg::alu_sra;
              end else begin
                op_o = exu_pkg::alu_srl;
              end
            end
            rv64_isa_pkg::F3_OR:      op_o = exu_pkg::alu_or;
            default:                  op_o = exu_pkg::alu_and;
          endcase
        end
      end
      rv64_isa_pkg::op_32, rv64_isa_pkg::op_imm_32: begin
        if (opcode == rv64_isa_pkg::op_32 && funct7 == rv64_isa_pkg::F7_MULDIV) begin
          if (funct3 == rv64_isa_pkg::F3_MUL) begin  // mulw only
            is_mul_o       = 1'b1;
            mul_req_o.word = 1'b1;
          end
        end else begin
          case (funct3)
            rv64_isa_pkg::F3_ADD_SUB: op_o = (opcode == rv64_isa_pkg::op_32 && funct7[5]) ?
                                             exu_pkg::alu_subw : exu_pkg::alu_addw;
            rv64_isa_pkg::F3_SLL:     op_o = exu_pkg::alu_sllw;
            rv64_isa_pkg::F3_SRL_SRA: op_o = funct7[5] ? exu_pkg::alu_sraw : exu_pkg::alu_srlw;
            default:                  op_o = exu_pkg::alu_zero;
          endcase
        end
      end
      rv64_isa_pkg::lui:    op_o = exu_pkg::alu_pass_b;
      rv64_isa_pkg::auipc,
      rv64_isa_pkg::load,
      rv64_isa_pkg::store,
      rv64_isa_pkg::jal:    op_o = exu_pkg::alu_add;  // address sums
      rv64_isa_pkg::jalr:   op_o = exu_pkg::alu_jalr_tgt;
      rv64_isa_pkg::branch: op_o = exu_pkg::alu_branch;
      default:              op_o = exu_pkg::alu_zero; // system and unknown
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/int_alu.sv
`default_nettype none

module int_alu (
  input  wire exu_pkg::alu_op_e op_i,
  input  wire [2:0]             funct3_i,
  input  wire exu_pkg::xlen_t   src_a_i,
  input  wire exu_pkg::xlen_t   src_b_i,
  output exu_pkg::xlen_t        result_o
);

  exu_pkg::xlen_t sum;
  exu_pkg::xlen_t diff;
  logic           lt_s;
  logic           lt_u;
  logic           take;
  logic [31:0]    word_res;

  assign sum  = src_a_i + src_b_i;
  assign diff = src_a_i - src_b_i;
  assign lt_s = $signed(src_a_i) < $signed(src_b_i);
  assign lt_u = src_a_i < src_b_i;

  // branch condition from funct3
  always_comb begin
    case (funct3_i)
      rv64_isa_pkg::F3_BEQ:  take = (src_a_i == src_b_i);
      rv64_isa_pkg::F3_BNE:  take = (src_a_i != src_b_i);
      rv64_isa_pkg::F3_BLT:  take = lt_s;
      rv64_isa_pkg::F3_BGE:  take = !lt_s;
      rv64_isa_pkg::F3_BLTU: take = lt_u;
      rv64_isa_pkg::F3_BGEU: take = !lt_u;
      default:               take = 1'b0;
    endcase
  end

  // 32-bit forms, shift amount is 5 bits
  always_comb begin
    case (op_i)
      exu_pkg::alu_subw: word_res = diff[31:0];
      exu_pkg::alu_sllw: word_res = src_a_i[31:0] << src_b_i[4:0];
      exu_pkg::alu_srlw: word_res = src_a_i[31:0] >> src_b_i[4:0];
      exu_pkg::alu_sraw: word_res = $signed(src_a_i[31:0]) >>> src_b_i[4:0];
      default:           word_res = sum[31:0];
    endcase
  end

  always_comb begin
    case (op_i)
      exu_pkg::alu_add:      result_o = sum;
      exu_pkg::alu_sub:      result_o = diff;
      exu_pkg::alu_sll:      result_o = src_a_i << src_b_i[5:0];
      exu_pkg::alu_srl:      result_o = src_a_i >> src_b_i[5:0];
      exu_pkg::alu_sra:      result_o = $signed(src_a_i) >>> src_b_i[5:0];
      exu_pkg::alu_slt:      result_o = {63'd0, lt_s};
      exu_pkg::alu_sltu:     result_o = {63'd0, lt_u};
      exu_pkg::alu_xor:      result_o = src_a_i ^ src_b_i;
      exu_pkg::alu_or:       result_o = src_a_i | src_b_i;
      exu_pkg::alu_and:      result_o = src_a_i & src_b_i;
      exu_pkg::alu_addw,
      exu_pkg::alu_subw,
      exu_pkg::alu_sllw,
      exu_pkg::alu_srlw,
      exu_pkg::alu_sraw:     result_o = {{32{word_res[31]}}, word_res};
      exu_pkg::alu_pass_b:   result_o = src_b_i;
      exu_pkg::alu_branch:   result_o = {63'd0, take};
      exu_pkg::alu_jalr_tgt: result_o = {sum[63:1], 1'b0};
      default:               result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/shift_add_mul.sv
`default_nettype none

module shift_add_mul #(
  parameter int MUL_CYCLES = exu_pkg::MUL_CYCLES
) (
  input  wire                    clk,
  input  wire                    arst_n_i,
  input  wire                    start_i,
  input  wire exu_pkg::mul_req_t req_i,
  input  wire exu_pkg::xlen_t    src_a_i,
  input  wire exu_pkg::xlen_t    src_b_i,
  output logic                   busy_o,
  output logic                   done_o,
  output exu_pkg::xlen_t         product_o
);

  localparam int CNT_W  = $clog2(MUL_CYCLES + 1);
  localparam int PROD_W = 2 * exu_pkg::XLEN;

  logic [CNT_W-1:0]  step_cnt;
  logic              last;
  logic              a_neg;
  logic              b_neg;
  logic              neg_q;
  exu_pkg::xlen_t    mag_a;
  exu_pkg::xlen_t    mag_b;
  exu_pkg::xlen_t    mplier;
  logic [PROD_W-1:0] mcand;
  logic [PROD_W-1:0] acc;
  logic [PROD_W-1:0] prod;
  exu_pkg::mul_req_t req_q;

  assign a_neg = req_i.a_signed & src_a_i[63];
  assign b_neg = req_i.b_signed & src_b_i[63];
  assign mag_a = a_neg ? -src_a_i : src_a_i;
  assign mag_b = b_neg ? -src_b_i : src_b_i;
  assign last  = (step_cnt == CNT_W'(MUL_CYCLES));

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_o   <= 1'b0;
      step_cnt <= '0;
    end else if (start_i) begin
      busy_o   <= 1'b1;
      step_cnt <= '0;
    end else if (busy_o) begin
      if (last) begin
        busy_o <= 1'b0;  // product taken this edge
      end else begin
        step_cnt <= step_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      acc    <= '0;
      mcand  <= {{exu_pkg::XLEN{1'b0}}, mag_a};
      mplier <= mag_b;
      neg_q  <= a_neg ^ b_neg;
      req_q  <= req_i;
    end else if (busy_o && !last) begin
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // final cycle: fix sign, pick the half
  assign prod   = neg_q ? -acc : acc;
  assign done_o = busy_o & last;

  always_comb begin
    if (req_q.word) begin
      product_o = {{32{prod[31]}}, prod[31:0]};
    end else if (req_q.take_high) begin
      product_o = prod[PROD_W-1:exu_pkg::XLEN];
    end else begin
      product_o = prod[exu_pkg::XLEN-1:0];
    end
  end

endmodule

`default_nettype wire

// File: rtl/exec_unit.sv
`default_nettype none

module exec_unit #(
  parameter int MUL_CYCLES = exu_pkg::MUL_CYCLES
) (
  input  wire                       clk,
  input  wire                       arst_n_i,
  input  wire                       valid_i,
  input  wire rv64_isa_pkg::instr_u instr_i,
  input  wire exu_pkg::xlen_t       src_a_i,
  input  wire exu_pkg::xlen_t       src_b_i,
  output exu_pkg::xlen_t            result_o,
  output logic                      done_o,
  output logic                      ready_o
);

  exu_pkg::alu_op_e  alu_op;
  exu_pkg::mul_req_t mul_req;
  exu_pkg::xlen_t    alu_result;
  exu_pkg::xlen_t    mul_product;
  logic              is_mul;
  logic              mul_busy;
  logic              mul_done;
  logic              accept;

  assign ready_o = !mul_busy;
  assign accept  = valid_i & ready_o;

  alu_op_decode alu_op_decode_inst (
    .instr_i   (instr_i),
    .op_o      (alu_op),
    .is_mul_o  (is_mul),
    .mul_req_o (mul_req)
  );

  int_alu int_alu_inst (
    .op_i     (alu_op),
    .funct3_i (instr_i.r_view.funct3),
    .src_a_i  (src_a_i),
    .src_b_i  (src_b_i),
    .result_o (alu_result)
  );

  shift_add_mul #(
    .MUL_CYCLES (MUL_CYCLES)
  ) shift_add_mul_inst (
    .clk       (clk),
    .arst_n_i  (arst_n_i),
    .start_i   (accept & is_mul),
    .req_i     (mul_req),
    .src_a_i   (src_a_i),
    .src_b_i   (src_b_i),
    .busy_o    (mul_busy),
    .done_o    (mul_done),
    .product_o (mul_product)
  );

  // mul_done only while busy, so it never meets an alu accept
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      done_o   <= 1'b0;
      result_o <= '0;
    end else begin
      done_o <= (accept & !is_mul) | mul_done;
      if (mul_done) begin
        result_o <= mul_product;
      end else if (accept && !is_mul) begin
        result_o <= alu_result;
      end
    end
  end

endmodule

`default_nettype wire

// File: testbench/exec_unit_props.sv
`default_nettype none

module exec_unit_props (
  input wire clk,
  input wire arst_n_i,
  input wire accept_i,
  input wire is_mul_i,
  input wire mul_done_i,
  input wire ready_i,
  input wire done_i
);

  a_done_single: assert property (@(posedge clk) disable iff (!arst_n_i)
    (!accept_i && !mul_done_i && $past(accept_i && !is_mul_i)) |=> !done_i)
    else $error("done_o stayed high with no new issue");

  // ready only comes back together with the product
  a_ready_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
    $rose(ready_i) |-> done_i)
    else $error("ready_o rose before done_o");

  a_alu_latency: assert property (@(posedge clk) disable iff (!arst_n_i)
    (accept_i && !is_mul_i) |=> done_i)
    else $error("alu issue without done_o on the next cycle");

  a_known: assert property (@(posedge clk) disable iff (!arst_n_i)
    !$isunknown({done_i, ready_i}))
    else $error("done_o or ready_o unknown");

endmodule

bind exec_unit exec_unit_props exec_unit_props_inst (
  .clk        (clk),
  .arst_n_i   (arst_n_i),
  .accept_i   (accept),
  .is_mul_i   (is_mul),
  .mul_done_i (mul_done),
  .ready_i    (ready_o),
  .done_i     (done_o)
);

`default_nettype wire

// File: testbench/exec_unit_tb.sv
`default_nettype none

module exec_unit_tb;

  localparam int RESET_CYCLES = 5;
  localparam int N_ISSUES     = 400;
  localparam int MUL_LAT      = exu_pkg::MUL_CYCLES + 1;
  localparam int CYCLE_LIMIT  = RESET_CYCLES + N_ISSUES * (exu_pkg::MUL_CYCLES + 2) + 200;

  typedef struct packed {
    exu_pkg::xlen_t value;
    logic [31:0]    due;  // negedge index where done_o is due
  } pending_t;

  logic                 clk;
  logic                 arst_n_i;
  logic                 valid_i;
  rv64_isa_pkg::instr_u instr_i;
  exu_pkg::xlen_t       src_a_i;
  exu_pkg::xlen_t       src_b_i;
  exu_pkg::xlen_t       result_o;
  logic                 done_o;
  logic                 ready_o;

  integer      seed;
  pending_t    exp_q[$];
  pending_t    item;
  logic        exp_done;
  int unsigned neg_cnt    = 0;
  int unsigned ready_at   = 0;
  int          accept_cnt = 0;
  int          cycle_cnt  = 0;
  int          err_result = 0;
  int          err_level  = 0;
  int          err_seq    = 0;

  exec_unit exec_unit_inst (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .valid_i  (valid_i),
    .instr_i  (instr_i),
    .src_a_i  (src_a_i),
    .src_b_i  (src_b_i),
    .result_o (result_o),
    .done_o   (done_o),
    .ready_o  (ready_o)
  );

  always #20 clk = ~clk;

  task automatic check_result(input string name, input exu_pkg::xlen_t got,
                              input exu_pkg::xlen_t exp);
    if (got !== exp) begin
      $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
      err_result++;
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error at %0t: %s got %b expected %b", $time, name, got, exp);
      err_level++;
    end
  endtask

  function automatic exu_pkg::xlen_t pick_operand();
    case ($unsigned($random(seed)) % 8)
      0:       return '0;
      1:       return '1;
      2:       return {1'b1, 63'd0};  // most negative
      default: return {$random(seed), $random(seed)};
    endcase
  endfunction

  function automatic logic is_multiply(rv64_isa_pkg::instr_u ins);
    if (ins.r_view.funct7 != 7'h01) return 1'b0;
    if (ins.r_view.opcode == rv64_isa_pkg::op) return !ins.r_view.funct3[2];
    if (ins.r_view.opcode == rv64_isa_pkg::op_32) return ins.r_view.funct3 == 3'd0;
    return 1'b0;
  endfunction

  // expected value straight from the RV64IM rules
  function automatic exu_pkg::xlen_t model_result(rv64_isa_pkg::instr_u ins,
                                                  exu_pkg::xlen_t a, exu_pkg::xlen_t b);
    logic [2:0]   f3;
    logic [6:0]   f7;
    logic         alt;
    logic [31:0]  w;
    logic [127:0] p;
    model_result = '0;
    f3  = ins.r_view.funct3;
    f7  = ins.r_view.funct7;
    alt = f7[5];
    case (ins.r_view.opcode)
      rv64_isa_pkg::op, rv64_isa_pkg::op_imm: begin
        if (ins.r_view.opcode == rv64_isa_pkg::op && f7 == 7'h01) begin
          if (f3[2]) return '0;  // div/rem
          p = {{64{a[63] & (f3 == 3'd1 || f3 == 3'd2)}}, a} * {{64{b[63] & (f3 == 3'd1)}}, b};
          return (f3 == 3'd0) ? p[63:0] : p[127:64];
        end
        if (ins.r_view.opcode == rv64_isa_pkg::op_imm) alt = ins.i_view.imm12[10];
        case (f3)
          3'd0:    return (ins.r_view.opcode == rv64_isa_pkg::op && alt) ? a - b : a + b;
          3'd1:    return a << b[5:0];
          3'd2:    return exu_pkg::xlen_t'($signed(a) < $signed(b));
          3'd3:    return exu_pkg::xlen_t'(a < b);
          3'd4:    return a ^ b;
          3'd5:    return alt ? exu_pkg::xlen_t'($signed(a) >>> b[5:0]) : a >> b[5:0];
          3'd6:    return a | b;
          default: return a & b;
        endcase
      end
      rv64_isa_pkg::op_32, rv64_isa_pkg::op_imm_32: begin
        if (ins.r_view.opcode == rv64_isa_pkg::op_32 && f7 == 7'h01) begin
          if (f3 != 3'd0) return '0;
          w = a[31:0] * b[31:0];
        end else begin
          case (f3)
            3'd0: begin
              if (ins.r_view.opcode == rv64_isa_pkg::op_32 && alt) begin
                w = a[31:0] - b[31:0];
              end else begin
                w = a[31:0] + b[31:0];
              end
            end
            3'd1:    w = a[31:0] << b[4:0];
            3'd5:    w = alt ? 32'($signed(a[31:0]) >>> b[4:0]) : a[31:0] >> b[4:0];
            default: return '0;
          endcase
        end
        return {{32{w[31]}}, w};
      end
      rv64_isa_pkg::lui:   return b;
      rv64_isa_pkg::auipc,
      rv64_isa_pkg::load,
      rv64_isa_pkg::store,
      rv64_isa_pkg::jal:   return a + b;
      rv64_isa_pkg::jalr:  return (a + b) & ~exu_pkg::xlen_t'(1);
      rv64_isa_pkg::branch: begin
        case (f3)
          3'd0:    return exu_pkg::xlen_t'(a == b);
          3'd1:    return exu_pkg::xlen_t'(a != b);
          3'd4:    return exu_pkg::xlen_t'($signed(a) < $signed(b));
          3'd5:    return exu_pkg::xlen_t'($signed(a) >= $signed(b));
          3'd6:    return exu_pkg::xlen_t'(a < b);
          default: return exu_pkg::xlen_t'(a >= b);
        endcase
      end
      default: return '0;
    endcase
  endfunction

  // pick one legal encoding from a table of 43 entries
  task automatic make_issue(output rv64_isa_pkg::instr_u ins, output exu_pkg::xlen_t a,
                            output exu_pkg::xlen_t b);
    int         sel;
    int         br;
    logic [5:0] shamt;
    logic       imm_form;
    sel      = int'($unsigned($random(seed)) % 43);
    shamt    = 6'($random(seed));
    br       = int'(shamt % 6);
    imm_form = 1'b0;
    ins      = 32'($random(seed));  // random rd, rs and immediate bits
    a        = pick_operand();
    b        = pick_operand();
    if (sel < 10) begin
      ins.r_view.opcode = rv64_isa_pkg::op;
      ins.r_view.funct3 = (sel < 8) ? 3'(sel) : ((sel == 8) ? 3'd0 : 3'd5);
      ins.r_view.funct7 = (sel >= 8) ? 7'h20 : 7'h00;  // sub, sra
    end else if (sel < 19) begin
      ins.r_view.opcode = rv64_isa_pkg::op_imm;
      ins.r_view.funct3 = (sel < 18) ? 3'(sel - 10) : 3'd5;
      imm_form          = 1'b1;
      if (ins.r_view.funct3 == 3'd1 || ins.r_view.funct3 == 3'd5) begin
        ins.i_view.imm12 = {1'b0, sel == 18, 4'd0, shamt};  // shamt[5] random
      end
    end else if (sel < 24) begin
      ins.r_view.opcode = rv64_isa_pkg::op_32;
      ins.r_view.funct3 = (sel < 21) ? 3'd0 : ((sel == 21) ? 3'd1 : 3'd5);
      ins.r_view.funct7 = (sel == 20 || sel == 23) ? 7'h20 : 7'h00;
    end else if (sel < 28) begin
      ins.r_view.opcode = rv64_isa_pkg::op_imm_32;
      ins.r_view.funct3 = (sel == 24) ? 3'd0 : ((sel == 25) ? 3'd1 : 3'd5);
      imm_form          = 1'b1;
      if (sel > 24) begin
        ins.i_view.imm12 = {1'b0, sel == 27, 5'd0, shamt[4:0]};
      end
    end else if (sel < 36) begin
      case (sel)
        28:      ins.r_view.opcode = rv64_isa_pkg::lui;
        29:      ins.r_view.opcode = rv64_isa_pkg::auipc;
        30:      ins.r_view.opcode = rv64_isa_pkg::load;
        31:      ins.r_view.opcode = rv64_isa_pkg::store;
        32:      ins.r_view.opcode = rv64_isa_pkg::jal;
        33:      ins.r_view.opcode = rv64_isa_pkg::jalr;
        34:      ins.r_view.opcode = rv64_isa_pkg::branch;
        default: ins.r_view.opcode = rv64_isa_pkg::system;
      endcase
      if (sel == 34) begin
        ins.r_view.funct3 = 3'((br < 2) ? br : br + 2);
        if (shamt[0]) b = a;  // equal operands now and then
      end
    end else begin
      if (sel == 40 || sel == 42) begin
        ins.r_view.opcode = rv64_isa_pkg::op_32;
      end else begin
        ins.r_view.opcode = rv64_isa_pkg::op;
      end
      ins.r_view.funct7 = 7'h01;
      ins.r_view.funct3 = (sel < 40) ? 3'(sel - 36) : ((sel == 40) ? 3'd0 : 3'(4 + shamt[1:0]));
    end
    if (imm_form) b = {{52{ins.i_view.imm12[11]}}, ins.i_view.imm12};
  endtask

  task automatic drive_issue();
    rv64_isa_pkg::instr_u ins;
    exu_pkg::xlen_t       a;
    exu_pkg::xlen_t       b;
    make_issue(ins, a, b);
    valid_i <= (($random(seed) & 7) != 0);  // keeps strobing while ready_o is low
    instr_i <= ins;
    src_a_i <= a;
    src_b_i <= b;
  endtask

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    if (arst_n_i) begin
      neg_cnt++;
      exp_done = (exp_q.size() != 0) && (exp_q[0].due == neg_cnt);
      check_level("done_o", done_o, exp_done);
      check_level("ready_o", ready_o, neg_cnt >= ready_at);
      if (done_o && exp_done) begin
        check_result("result_o", result_o, exp_q[0].value);
        void'(exp_q.pop_front());
      end else if (exp_q.size() != 0 && exp_q[0].due <= neg_cnt) begin
        $display("result due at cycle %0d never came with done_o", exp_q[0].due);
        err_seq++;
        void'(exp_q.pop_front());
      end
      if (valid_i && ready_o) begin
        item.value = model_result(instr_i, src_a_i, src_b_i);
        item.due   = neg_cnt + 1 + (is_multiply(instr_i) ? MUL_LAT : 0);
        exp_q.push_back(item);
        if (is_multiply(instr_i)) ready_at = neg_cnt + 2 + exu_pkg::MUL_CYCLES;
        accept_cnt++;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles with %0d results outstanding", cycle_cnt, exp_q.size());
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    seed     = 32'h957e_f994;
    clk      = 1'b0;
    arst_n_i = 1'b0;
    valid_i  = 1'b0;
    instr_i  = '0;
    src_a_i  = '0;
    src_b_i  = '0;
    repeat (RESET_CYCLES - 1) @(posedge clk);
    @(negedge clk);
    check_level("done_o", done_o, 1'b0);
    check_level("ready_o", ready_o, 1'b1);
    check_result("result_o", result_o, '0);
    @(posedge clk);
    arst_n_i <= 1'b1;
    while (accept_cnt < N_ISSUES) begin
      drive_issue();
      @(posedge clk);
    end
    valid_i <= 1'b0;
    while (exp_q.size() != 0) @(posedge clk);
    repeat (4) @(posedge clk);  // no stray done_o after the last result
    $display("%0d issues, %0d result errors, %0d level errors, %0d sequence errors",
             accept_cnt, err_result, err_level, err_seq);
    if (err_result + err_level + err_seq == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
rtl/rv64_isa_pkg.sv
rtl/exu_pkg.sv
rtl/alu_op_decode.sv
rtl/int_alu.sv
rtl/shift_add_mul.sv
rtl/exec_unit.sv
testbench/exec_unit_props.sv
testbench/exec_unit_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= exec_unit_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$($(OBJ_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
